/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_axi_recorder
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/axi_mstr_recorder.sv */
`timescale 1ns/10ps

module axi_mstr_recorder
   import rr_axi_pkg::*;
   import rr_log_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst,
   // AW from shell, to custom logic
   input  logic      i_s_awvalid,
   output logic      o_s_awready,
   input  axi_id_t   i_s_awid,
   input  axi_addr_t i_s_awaddr,
   output logic      o_m_awvalid,
   input  logic      i_m_awready,
   output axi_id_t   o_m_awid,
   output axi_addr_t o_m_awaddr,
   // B from custom logic, back to shell
   input  logic      i_m_bvalid,
   output logic      o_m_bready,
   input  axi_id_t   i_m_bid,
   input  axi_resp_t i_m_bresp,
   output logic      o_s_bvalid,
   input  logic      i_s_bready,
   output axi_id_t   o_s_bid,
   output axi_resp_t o_s_bresp,
   // Log readout
   input  logic      i_psel,
   input  logic      i_penable,
   input  logic      i_pwrite,
   input  apb_addr_t i_paddr,
   output apb_data_t o_prdata,
   output logic      o_pready,
   output logic      o_pslverr
);

axi_aw_t    aw_in;
axi_aw_t    aw_out;
axi_b_t     b_in;
axi_b_t     b_out;
log_count_t count;
log_entry_t head;
logic       pop;

assign aw_in = {i_s_awid, i_s_awaddr};
assign {o_m_awid, o_m_awaddr} = aw_out;
assign b_in = {i_m_bid, i_m_bresp};
assign {o_s_bid, o_s_bresp} = b_out;

rr_log_if #(.LOGB_WIDTH(AXI_AW_WIDTH)) aw_log ();
// B only logs its end event
rr_log_if #(.LOGB_WIDTH(0)) b_log ();

channel_logger #(
   .DATA_WIDTH(AXI_AW_WIDTH)
) aw_logger (
   .clk(clk),
   .i_rst(i_rst),
   .i_in_valid(i_s_awvalid),
   .o_in_ready(o_s_awready),
   .i_in_data(aw_in),
   .o_out_valid(o_m_awvalid),
   .i_out_ready(i_m_awready),
   .o_out_data(aw_out),
   .log(aw_log.P)
);

channel_logger #(
   .DATA_WIDTH(AXI_B_WIDTH)
) b_logger (
   .clk(clk),
   .i_rst(i_rst),
   .i_in_valid(i_m_bvalid),
   .o_in_ready(o_m_bready),
   .i_in_data(b_in),
   .o_out_valid(o_s_bvalid),
   .i_out_ready(i_s_bready),
   .o_out_data(b_out),
   .log(b_log.P)
);

log_packer packer (
   .clk(clk),
   .i_rst(i_rst),
   .aw_log(aw_log.C),
   .b_log(b_log.C),
   .o_count(count),
   .o_head(head),
   .i_pop(pop)
);

log_apb_reader reader (
   .clk(clk),
   .i_rst(i_rst),
   .i_psel(i_psel),
   .i_penable(i_penable),
   .i_pwrite(i_pwrite),
   .i_paddr(i_paddr),
   .o_prdata(o_prdata),
   .o_pready(o_pready),
   .o_pslverr(o_pslverr),
   .i_count(count),
   .i_head(head),
   .o_pop(pop)
);

endmodule

/* hw/channel_logger.sv */
`timescale 1ns/10ps

module channel_logger #(
   parameter int DATA_WIDTH = 8
) (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_in_valid,
   output logic                  o_in_ready,
   input  logic [DATA_WIDTH-1:0] i_in_data,
   output logic                  o_out_valid,
   input  logic                  i_out_ready,
   output logic [DATA_WIDTH-1:0] o_out_data,
   rr_log_if.P                   log
);

logic                  full;
logic [DATA_WIDTH-1:0] data_q;
logic                  in_hs;
logic                  out_hs;

// Accept when the slot frees up this cycle, unless the log is close to full
assign o_in_ready = (!full || i_out_ready) && !log.almful;

assign in_hs  = i_in_valid && o_in_ready;
assign out_hs = full && i_out_ready;

assign o_out_valid = full;
assign o_out_data  = data_q;

always_ff @(posedge clk) begin
   if (i_rst) begin
      full <= 1'b0;
   end else if (in_hs) begin
      full <= 1'b1;
   end else if (out_hs) begin
      full <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (in_hs) begin
      data_q <= i_in_data;
   end
end

// End event when the far side takes the item
assign log.loge_valid = out_hs;

// Begin event only on channels that log a payload
generate
   if (log.LOGB_WIDTH > 0) begin : g_logb
      assign log.logb_valid = in_hs;
      assign log.logb_data  = i_in_data;
   end else begin : g_no_logb
      assign log.logb_valid = 1'b0;
      assign log.logb_data  = '0;
   end
endgenerate

endmodule

/* hw/log_apb_reader.sv */
`timescale 1ns/10ps

module log_apb_reader
   import rr_log_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_psel,
   input  logic       i_penable,
   input  logic       i_pwrite,
   input  apb_addr_t  i_paddr,
   output apb_data_t  o_prdata,
   output logic       o_pready,
   output logic       o_pslverr,
   input  log_count_t i_count,
   input  log_entry_t i_head,
   output logic       o_pop
);

reader_state_t state;
reader_state_t state_next;
logic          access;
logic          hit_status;
logic          hit_data;
logic          log_empty;
logic          err;

always_ff @(posedge clk) begin
   if (i_rst) begin
      state <= IDLE;
   end else begin
      state <= state_next;
   end
end

always_comb begin
   state_next = state;
   case (state)
      IDLE:   if (i_psel && !i_penable) state_next = ACCESS;
      ACCESS: state_next = IDLE;
      default: state_next = IDLE;
   endcase
end

assign access     = (state == ACCESS) && i_psel && i_penable;
assign hit_status = (i_paddr == REG_STATUS);
assign hit_data   = (i_paddr == REG_DATA);
assign log_empty  = (i_count == '0);

// Writes, unmapped reads and reads of an empty log
assign err = i_pwrite || !(hit_status || hit_data) || (hit_data && log_empty);

assign o_pready  = (state == ACCESS);
assign o_pslverr = access && err;

// Pop lands on the same edge that completes the read
assign o_pop = access && !err && hit_data;

always_comb begin
   o_prdata = '0;
   if (access && !i_pwrite) begin
      if (hit_status) begin
         o_prdata = apb_data_t'(i_count);
      end else if (hit_data && !log_empty) begin
         o_prdata = apb_data_t'(i_head);
      end
   end
end

endmodule

/* hw/log_packer.sv */
`timescale 1ns/10ps

module log_packer
   import rr_log_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst,
   rr_log_if.C        aw_log,
   rr_log_if.C        b_log,
   output log_count_t o_count,
   output log_entry_t o_head,
   input  logic       i_pop
);

log_entry_t mem [LOG_DEPTH];
log_ptr_t   wr_ptr;
log_ptr_t   rd_ptr;
log_count_t count_q;
log_count_t count_next;
logic       almful_q;
log_entry_t entry;
logic       push;
logic       pop;

// One entry per cycle with all events of that cycle
assign entry = {aw_log.logb_data, aw_log.logb_valid, aw_log.loge_valid, b_log.loge_valid};
assign push  = aw_log.logb_valid || aw_log.loge_valid || b_log.loge_valid;
assign pop   = i_pop && (count_q != '0);

always_comb begin
   count_next = count_q + log_count_t'(push) - log_count_t'(pop);
end

always_ff @(posedge clk) begin
   if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count_q  <= '0;
      almful_q <= 1'b0;
   end else begin
      if (push) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
      count_q  <= count_next;
      // Tracks the new count so it lines up with o_count
      almful_q <= (count_next >= LOG_ALMFUL_LEVEL);
   end
end

always_ff @(posedge clk) begin
   if (push) begin
      mem[wr_ptr] <= entry;
   end
end

assign o_head  = mem[rd_ptr];
assign o_count = count_q;

// Same stall level for both channels
assign aw_log.almful = almful_q;
assign b_log.almful  = almful_q;

endmodule

/* hw/rr_axi_pkg.sv */
package rr_axi_pkg;

// Field widths of the recorded AXI channels
localparam int AXI_ID_WIDTH   = 4;
localparam int AXI_ADDR_WIDTH = 16;
localparam int AXI_RESP_WIDTH = 2;

typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
typedef logic [AXI_RESP_WIDTH-1:0] axi_resp_t;

// AW payload with the id in the upper bits and the address below
localparam int AXI_AW_WIDTH = AXI_ID_WIDTH + AXI_ADDR_WIDTH;

// B payload with the id in the upper bits and the response below
localparam int AXI_B_WIDTH = AXI_ID_WIDTH + AXI_RESP_WIDTH;

typedef logic [AXI_AW_WIDTH-1:0] axi_aw_t;
typedef logic [AXI_B_WIDTH-1:0]  axi_b_t;

endpackage

/* hw/rr_log_if.sv */
`timescale 1ns/10ps

// Log signals of one channel; LOGB_WIDTH of 0 means no begin payload
interface rr_log_if #(
   parameter int LOGB_WIDTH = 1
);
logic                                          logb_valid;
logic [((LOGB_WIDTH > 0) ? LOGB_WIDTH : 1)-1:0] logb_data;
logic                                          loge_valid;
logic                                          almful;

modport P (
   output logb_valid, logb_data, loge_valid,
   input  almful
);

modport C (
   input  logb_valid, logb_data, loge_valid,
   output almful
);
endinterface

/* hw/rr_log_pkg.sv */
package rr_log_pkg;
import rr_axi_pkg::*;

// Entry fields from the top are AW payload, logb_aw, loge_aw and loge_b
localparam int LOG_ENTRY_WIDTH = AXI_AW_WIDTH + 3;
typedef logic [LOG_ENTRY_WIDTH-1:0] log_entry_t;

localparam int LOG_DEPTH     = 16;
localparam int LOG_PTR_WIDTH = $clog2(LOG_DEPTH);
typedef logic [LOG_PTR_WIDTH-1:0] log_ptr_t;
typedef logic [LOG_PTR_WIDTH:0]   log_count_t;

// Two slots of margin for entries still in flight
localparam log_count_t LOG_ALMFUL_LEVEL = log_count_t'(LOG_DEPTH - 2);

localparam int APB_ADDR_WIDTH = 8;
localparam int APB_DATA_WIDTH = 32;
typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

localparam apb_addr_t REG_STATUS = 8'h00;
localparam apb_addr_t REG_DATA   = 8'h04;

typedef enum logic {IDLE, ACCESS} reader_state_t;

endpackage

/* project.f */
hw/rr_axi_pkg.sv
hw/rr_log_pkg.sv
hw/rr_log_if.sv
hw/channel_logger.sv
hw/log_packer.sv
hw/log_apb_reader.sv
hw/axi_mstr_recorder.sv
test/recorder_assertions.sv
test/tb_axi_recorder.sv

/* test/recorder_assertions.sv */
`timescale 1ns/10ps

module recorder_assertions #(
   parameter int DATA_WIDTH = 8
) (
   input logic                  clk,
   input logic                  i_rst,
   input logic                  i_in_valid,
   input logic                  i_in_ready,
   input logic                  i_out_valid,
   input logic                  i_out_ready,
   input logic [DATA_WIDTH-1:0] i_out_data,
   input logic                  i_almful
);

logic pending;
int   wait_cnt;

// Accepted item still owed to the far side
always_ff @(posedge clk) begin
   if (i_rst) begin
      pending <= 1'b0;
   end else if (i_in_valid && i_in_ready) begin
      pending <= 1'b1;
   end else if (i_out_valid && i_out_ready) begin
      pending <= 1'b0;
   end
end

// Cycles the owed item has waited for its output handshake
always_ff @(posedge clk) begin
   if (i_rst || !pending || (i_out_valid && i_out_ready)) begin
      wait_cnt <= 0;
   end else begin
      wait_cnt <= wait_cnt + 1;
   end
end

// Held item keeps its payload until the far side takes it
a_out_stable: assert property (@(posedge clk) disable iff (i_rst)
   (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
   else $error("slice output changed or dropped while stalled");

a_stall: assert property (@(posedge clk) disable iff (i_rst)
   i_almful |-> !i_in_ready)
   else $error("input accepted while the log was almost full");

a_no_loss: assert property (@(posedge clk) disable iff (i_rst)
   pending |-> i_out_valid)
   else $error("accepted item missing at slice output");

// Random far-side ready never stays low this long
a_delivered: assert property (@(posedge clk) disable iff (i_rst)
   wait_cnt < 64)
   else $error("accepted item never taken by the far side");

endmodule

bind channel_logger recorder_assertions #(
   .DATA_WIDTH(DATA_WIDTH)
) u_checks (
   .clk(clk),
   .i_rst(i_rst),
   .i_in_valid(i_in_valid),
   .i_in_ready(o_in_ready),
   .i_out_valid(o_out_valid),
   .i_out_ready(i_out_ready),
   .i_out_data(o_out_data),
   .i_almful(log.almful)
);

/* test/recorder_testdata.txt */
// Word 0: number of AW requests, then one AW word per request {id[3:0], addr[15:0]}
// Then one B word per request {id[3:0], resp[1:0]}, in the same order
14
// AW requests
10100
20204
30308
41000
51a2c
62f00
73344
84000
95550
a6a6c
b7ff0
c8000
d9124
ea0a0
fbeef
0c004
1d008
2e00c
3f010
4fffc
// B responses
04
09
0c
12
14
1b
1c
21
24
2a
2c
30
37
38
3d
00
06
08
0c
11

/* test/tb_axi_recorder.sv */
`timescale 1ns/10ps

module tb_axi_recorder
   import rr_axi_pkg::*;
   import rr_log_pkg::*;
();

logic      clk = 1'b0;
logic      i_rst = 1'b1;
logic      i_s_awvalid = 1'b0;
logic      o_s_awready;
axi_id_t   i_s_awid = '0;
axi_addr_t i_s_awaddr = '0;
logic      o_m_awvalid;
logic      i_m_awready = 1'b0;
axi_id_t   o_m_awid;
axi_addr_t o_m_awaddr;
logic      i_m_bvalid = 1'b0;
logic      o_m_bready;
axi_id_t   i_m_bid = '0;
axi_resp_t i_m_bresp = '0;
logic      o_s_bvalid;
logic      i_s_bready = 1'b0;
axi_id_t   o_s_bid;
axi_resp_t o_s_bresp;
logic      i_psel = 1'b0;
logic      i_penable = 1'b0;
logic      i_pwrite = 1'b0;
apb_addr_t i_paddr = '0;
apb_data_t o_prdata;
logic      o_pready;
logic      o_pslverr;

logic [31:0] tdata [0:63];
int          num_req = 0;
int          timeout_limit = 2000;
int          cycle_cnt = 0;
int          aw_in_cnt = 0;
int          aw_out_cnt = 0;
int          b_out_cnt = 0;
int          model_count = 0;
int          value_errs = 0;
int          other_errs = 0;
logic        traffic_on = 1'b0;
logic [31:0] lfsr = 32'h24dc_b357;
log_entry_t  exp_q [$];
axi_b_t      b_pend [$];

axi_mstr_recorder dut0 (.*);

always #20 clk = ~clk;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
   end
   return s >> 1;
endfunction

task automatic apb_xfer(input logic wr, input apb_addr_t addr,
                        output logic err, output apb_data_t data);
   @(negedge clk);
   i_psel    = 1'b1;
   i_penable = 1'b0;
   i_pwrite  = wr;
   i_paddr   = addr;
   @(negedge clk);
   i_penable = 1'b1;
   @(posedge clk);
   err  = o_pslverr;
   data = o_prdata;
   @(negedge clk);
   i_psel    = 1'b0;
   i_penable = 1'b0;
   i_pwrite  = 1'b0;
endtask

// One LFSR bit per ready decision
always @(negedge clk) begin
   if (traffic_on && aw_in_cnt < num_req) begin
      i_s_awvalid = 1'b1;
      {i_s_awid, i_s_awaddr} = tdata[1 + aw_in_cnt][19:0];
   end else begin
      i_s_awvalid = 1'b0;
   end
   if (b_pend.size() > 0) begin
      i_m_bvalid = 1'b1;
      {i_m_bid, i_m_bresp} = b_pend[0];
   end else begin
      i_m_bvalid = 1'b0;
   end
   if (traffic_on) begin
      i_m_awready = lfsr[0];
      lfsr = lfsr_step(lfsr);
      i_s_bready = lfsr[0];
      lfsr = lfsr_step(lfsr);
   end
end

always @(posedge clk) begin
   cycle_cnt++;
   if (cycle_cnt >= timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $finish;
   end
end

// Scoreboard sees the ports as they were just before this edge
always @(posedge clk) begin : monitor
   log_entry_t exp_e;
   log_entry_t got_e;
   logic       ev_b;
   logic       ev_ae;
   logic       ev_be;
   if (!i_rst) begin
      ev_b  = i_s_awvalid && o_s_awready;
      ev_ae = o_m_awvalid && i_m_awready;
      ev_be = o_s_bvalid && i_s_bready;
      // Ready only in the access phase
      assert (o_pready == (i_psel && i_penable)) else begin
         $display("FAIL @ %0t: pready %b out of step with the APB phase", $time, o_pready);
         value_errs++;
      end
      if (i_psel && i_penable && !i_pwrite && i_paddr == REG_STATUS) begin
         assert (o_prdata == 32'(model_count)) else begin
            $display("FAIL @ %0t: status %0d, expected %0d", $time, o_prdata, model_count);
            value_errs++;
         end
      end
      if (i_psel && i_penable && !i_pwrite && i_paddr == REG_DATA) begin
         assert (o_pslverr == (model_count == 0)) else begin
            $display("FAIL @ %0t: data read pslverr %b with %0d entries", $time,
                     o_pslverr, model_count);
            value_errs++;
         end
         assert (o_pslverr || exp_q.size() > 0) else begin
            $display("Log returned an entry that no handshake produced");
            other_errs++;
         end
         if (!o_pslverr && exp_q.size() > 0) begin
            exp_e = exp_q.pop_front();
            got_e = o_prdata[LOG_ENTRY_WIDTH-1:0];
            // Payload only means something with the begin bit set
            assert (got_e[2:0] == exp_e[2:0] && (!exp_e[2] ||
                    got_e[LOG_ENTRY_WIDTH-1:3] == exp_e[LOG_ENTRY_WIDTH-1:3])) else begin
               $display("FAIL @ %0t: log entry %h, expected %h", $time, got_e, exp_e);
               value_errs++;
            end
            model_count--;
         end
      end
      if (model_count >= int'(LOG_ALMFUL_LEVEL)) begin
         assert (!o_s_awready && !o_m_bready) else begin
            $display("FAIL @ %0t: ready high with %0d entries (awready %b, bready %b)",
                     $time, model_count, o_s_awready, o_m_bready);
            value_errs++;
         end
      end
      assert (model_count <= LOG_DEPTH) else begin
         $display("Log holds %0d entries, more than its depth", model_count);
         other_errs++;
      end
      if (ev_b) begin
         aw_in_cnt++;
      end
      if (i_m_bvalid && o_m_bready) begin
         void'(b_pend.pop_front());
      end
      if (ev_ae) begin
         assert ({o_m_awid, o_m_awaddr} == tdata[1 + aw_out_cnt][19:0]) else begin
            $display("FAIL @ %0t: AW out %h, expected %h", $time, {o_m_awid, o_m_awaddr},
                     tdata[1 + aw_out_cnt][19:0]);
            value_errs++;
         end
         b_pend.push_back(tdata[1 + num_req + aw_out_cnt][5:0]);
         aw_out_cnt++;
      end
      if (ev_be) begin
         assert ({o_s_bid, o_s_bresp} == tdata[1 + num_req + b_out_cnt][5:0]) else begin
            $display("FAIL @ %0t: B out %h, expected %h", $time, {o_s_bid, o_s_bresp},
                     tdata[1 + num_req + b_out_cnt][5:0]);
            value_errs++;
         end
         b_out_cnt++;
      end
      if (ev_b || ev_ae || ev_be) begin
         exp_q.push_back({i_s_awid, i_s_awaddr, ev_b, ev_ae, ev_be});
         model_count++;
      end
   end
end

initial begin
   logic      err;
   apb_data_t rdata;
   $readmemh("test/recorder_testdata.txt", tdata);
   num_req = int'(tdata[0]);
   timeout_limit = 40 * num_req + 2000;
   repeat (2) @(posedge clk);
   @(negedge clk);
   i_rst = 1'b0;

   assert (!o_m_awvalid && !o_s_bvalid && !o_pready) else begin
      $display("FAIL @ %0t: outputs not idle after reset", $time);
      value_errs++;
   end
   apb_xfer(1'b0, REG_STATUS, err, rdata);
   assert (!err && rdata == 32'd0) else begin
      $display("FAIL @ %0t: status after reset %h, pslverr %b", $time, rdata, err);
      value_errs++;
   end
   apb_xfer(1'b0, REG_DATA, err, rdata);
   assert (err) else begin
      $display("FAIL @ %0t: empty data read gave no pslverr", $time);
      value_errs++;
   end
   apb_xfer(1'b0, 8'h08, err, rdata);
   assert (err) else begin
      $display("FAIL @ %0t: unmapped read gave no pslverr", $time);
      value_errs++;
   end
   apb_xfer(1'b1, REG_STATUS, err, rdata);
   assert (err) else begin
      $display("FAIL @ %0t: write gave no pslverr", $time);
      value_errs++;
   end

   // No draining until the log stalls the AW channel
   @(posedge clk);
   traffic_on = 1'b1;
   while (model_count < int'(LOG_ALMFUL_LEVEL) && b_out_cnt < num_req) begin
      @(negedge clk);
   end
   assert (model_count >= int'(LOG_ALMFUL_LEVEL)) else begin
      $display("Log never reached the almost full level");
      other_errs++;
   end
   repeat (40) @(negedge clk);

   while (!(aw_out_cnt == num_req && b_out_cnt == num_req && model_count == 0)) begin
      apb_xfer(1'b0, REG_STATUS, err, rdata);
      if (rdata != 32'd0) begin
         apb_xfer(1'b0, REG_DATA, err, rdata);
      end
   end
   assert (exp_q.size() == 0 && b_pend.size() == 0) else begin
      $display("Expected entries or responses left over at the end");
      other_errs++;
   end

   $display("Errors: %0d value, %0d other", value_errs, other_errs);
   if (value_errs == 0 && other_errs == 0) begin
      $display("*** TEST PASSED ***");
   end else begin
      $display("*** TEST FAILED ***");
   end
   $finish;
end

endmodule
